/* flist.f */
logic/la_pkg.sv
logic/la_uop_if.sv
logic/la_decode.sv
logic/la_execute.sv
logic/la_result.sv
logic/la_apb_port.sv
logic/la_exec_top.sv
test/tb_la_exec.sv

/* run.sh */
#!/bin/sh
# build and run the LA32R execution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_la_exec \
    -Mdir obj_dir -o sim_la_exec
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_la_exec 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "TEST PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* test/tb_la_exec.sv */
// tb_la_exec
// testbench for the LA32R execution unit, drives APB, runs an
// instruction table and random R-type ops against a reference ALU

`timescale 1ns/1ps

module tb_la_exec;
    import la_pkg::*;

    localparam int WAIT_LIMIT = 40;
    localparam int RANDOM_OPS = 40;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
    word_t prdata;
    logic  pready;
    logic  pslverr;

    int    seed = 32'h78d01f34;
    int    valid_issued = 0;
    word_t tbl_inst [$];
    word_t tbl_exp  [$];

    la_exec_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////
    function automatic word_t rtype_word(alu_op_t op, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {1'b0, 12'b000000000010, op, rk, rj, rd};
    endfunction

    function automatic word_t sra_word(reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {1'b0, 16'b0000000000110000, rk, rj, rd};
    endfunction

    function automatic word_t imm_word(logic [2:0] sub, reg_idx_t rd, reg_idx_t rj,
                                       logic [11:0] imm);
        return {1'b0, 6'b000001, sub, imm, rj, rd};
    endfunction

    function automatic word_t shift_word(logic [1:0] kind, reg_idx_t rd, reg_idx_t rj,
                                         logic [4:0] ui5);
        return {1'b0, 11'b00000000100, kind, 3'b001, ui5, rj, rd};
    endfunction

    function automatic word_t lui_word(reg_idx_t rd, logic [19:0] si20);
        return {1'b0, 6'b001010, si20, rd};
    endfunction

    function automatic addr_t rf_addr(reg_idx_t n);
        return ADDR_RF_BASE + {5'b0, n, 2'b00};
    endfunction

    // distinct per register
    function automatic word_t reg_pattern(reg_idx_t n);
        return {n, ~n, n, ~n, n, ~n, 2'b10};
    endfunction

    // reference ALU for the random R-type ops
    function automatic word_t expect_alu(alu_op_t op, word_t a, word_t b);
        word_t r;
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_XOR:  r = a ^ b;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            default:  r = 32'd0;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////
    // checks and APB driver
    ////////////////////////////////////////
    task automatic check_word(string name, word_t got, word_t exp_val);
        assert (got === exp_val) else begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp_val);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // one APB transfer
    // waits returns the number of stalled access cycles
    task automatic bus_access(input logic wr, input addr_t addr, input word_t wdata,
                              output word_t rdata, output logic err, output int waits);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        // sample mid cycle between the edges
        #5;
        while (!pready) begin
            if (waits >= WAIT_LIMIT) begin
                $display("timeout: pready stayed low for %0d cycles at address 0x%h",
                         WAIT_LIMIT, addr);
                $display("TEST FAILED");
                $fatal(1, "bus access timed out");
            end
            @(negedge clk);
            #5;
            waits++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(addr_t addr, word_t data);
        word_t unused_rd;
        logic  err;
        int    waits;
        bus_access(1'b1, addr, data, unused_rd, err, waits);
        check_word("pslverr", {31'b0, err}, 32'd0);
    endtask

    task automatic apb_read(input addr_t addr, output word_t data);
        logic err;
        int   waits;
        bus_access(1'b0, addr, '0, data, err, waits);
        check_word("pslverr", {31'b0, err}, 32'd0);
    endtask

    task automatic read_expect_error(addr_t addr);
        word_t data;
        logic  err;
        int    waits;
        bus_access(1'b0, addr, '0, data, err, waits);
        check_word("pslverr", {31'b0, err}, 32'd1);
    endtask

    task automatic add_case(word_t inst, word_t exp_val);
        tbl_inst.push_back(inst);
        tbl_exp.push_back(exp_val);
    endtask

    // invalid op must leave r28 alone and raise the sticky flag
    task automatic run_invalid(word_t inst);
        word_t got;
        apb_write(rf_addr(5'd28), 32'h0BAD_F00D);
        apb_write(ADDR_INST, inst);
        apb_read(rf_addr(5'd28), got);
        check_word("r28", got, 32'h0BAD_F00D);
        apb_read(ADDR_STATUS, got);
        check_word("status", got, 32'h0000_0002);
        apb_read(ADDR_RETIRED, got);
        check_word("retired", got, word_t'(valid_issued));
        apb_write(ADDR_STATUS, 32'h0000_0002);
        apb_read(ADDR_STATUS, got);
        check_word("status", got, 32'd0);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        word_t    got;
        word_t    va;
        word_t    vb;
        word_t    rnd;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        alu_op_t  op;
        logic     err;
        int       waits;
        int       i;

        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // reset state
        check_word("pslverr", {31'b0, pslverr}, 32'd0);
        check_word("pready", {31'b0, pready}, 32'd1);
        apb_read(ADDR_STATUS, got);
        check_word("status", got, 32'd0);
        apb_read(ADDR_RETIRED, got);
        check_word("retired", got, 32'd0);
        for (i = 0; i < NUM_REGS; i++) begin
            apb_read(rf_addr(reg_idx_t'(i)), got);
            check_word($sformatf("r%0d", i), got, 32'd0);
        end

        // host access to the register file
        for (i = 1; i < NUM_REGS; i++) begin
            apb_write(rf_addr(reg_idx_t'(i)), reg_pattern(reg_idx_t'(i)));
        end
        for (i = 1; i < NUM_REGS; i++) begin
            apb_read(rf_addr(reg_idx_t'(i)), got);
            check_word($sformatf("r%0d", i), got, reg_pattern(reg_idx_t'(i)));
        end
        apb_write(rf_addr(5'd0), 32'hDEAD_BEEF);
        apb_read(rf_addr(5'd0), got);
        check_word("r0", got, 32'd0);
        read_expect_error(12'h00C);
        read_expect_error(12'h100);
        read_expect_error(12'h082);
        read_expect_error(ADDR_INST);

        // operands for the table
        apb_write(rf_addr(5'd1), 32'h8000_00F0);
        apb_write(rf_addr(5'd2), 32'h1234_5678);
        apb_write(rf_addr(5'd3), 32'h0000_0025);
        apb_write(rf_addr(5'd4), 32'hFFFF_FFFF);

        add_case(rtype_word(ALU_ADD,  5'd5,  5'd1, 5'd2), 32'h9234_5768);
        add_case(rtype_word(ALU_SUB,  5'd6,  5'd2, 5'd1), 32'h9234_5588);
        add_case(rtype_word(ALU_SLT,  5'd7,  5'd1, 5'd2), 32'h0000_0001);
        add_case(rtype_word(ALU_SLTU, 5'd8,  5'd1, 5'd2), 32'h0000_0000);
        add_case(rtype_word(ALU_NOR,  5'd9,  5'd1, 5'd2), 32'h6DCB_A907);
        add_case(rtype_word(ALU_AND,  5'd10, 5'd1, 5'd2), 32'h0000_0070);
        add_case(rtype_word(ALU_OR,   5'd11, 5'd1, 5'd2), 32'h9234_56F8);
        add_case(rtype_word(ALU_XOR,  5'd12, 5'd1, 5'd2), 32'h9234_5688);
        // r3 holds 37 so these shift by 5
        add_case(rtype_word(ALU_SLL,  5'd13, 5'd2, 5'd3), 32'h468A_CF00);
        add_case(rtype_word(ALU_SRL,  5'd14, 5'd1, 5'd3), 32'h0400_0007);
        add_case(sra_word(5'd15, 5'd1, 5'd3),             32'hFC00_0007);
        add_case(imm_word(3'b000, 5'd16, 5'd1, 12'h7FF),  32'h0000_0001);
        add_case(imm_word(3'b001, 5'd17, 5'd2, 12'hFFF),  32'h0000_0001);
        add_case(imm_word(3'b010, 5'd18, 5'd2, 12'h800),  32'h1234_4E78);
        add_case(imm_word(3'b101, 5'd19, 5'd4, 12'hABC),  32'h0000_0ABC);
        add_case(imm_word(3'b110, 5'd20, 5'd1, 12'hF0F),  32'h8000_0FFF);
        add_case(imm_word(3'b111, 5'd21, 5'd2, 12'hFFF),  32'h1234_5987);
        add_case(shift_word(2'b00, 5'd22, 5'd2, 5'd8),    32'h3456_7800);
        add_case(shift_word(2'b01, 5'd23, 5'd1, 5'd31),   32'h0000_0001);
        add_case(shift_word(2'b10, 5'd24, 5'd1, 5'd4),    32'hF800_000F);
        add_case(lui_word(5'd25, 20'hABCDE),              32'hABCD_E000);
        add_case(lui_word(5'd26, 20'h00001),              32'h0000_1000);

        foreach (tbl_inst[n]) begin
            rd = tbl_inst[n][4:0];
            apb_write(ADDR_INST, tbl_inst[n]);
            valid_issued++;
            apb_read(rf_addr(rd), got);
            check_word($sformatf("r%0d", rd), got, tbl_exp[n]);
        end
        apb_read(ADDR_RETIRED, got);
        check_word("retired", got, word_t'(valid_issued));

        // read right behind an instruction has to stall for the new value
        apb_write(rf_addr(5'd27), 32'h5A5A_5A5A);
        apb_write(ADDR_INST, rtype_word(ALU_ADD, 5'd27, 5'd1, 5'd2));
        valid_issued++;
        bus_access(1'b0, rf_addr(5'd27), '0, got, err, waits);
        assert (waits > 0) else begin
            $display("read after an instruction write completed without a stall");
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
        check_word("pslverr", {31'b0, err}, 32'd0);
        check_word("r27", got, 32'h9234_5768);

        // invalid encodings
        run_invalid(32'h8000_0000 | rtype_word(ALU_ADD, 5'd28, 5'd1, 5'd2));
        run_invalid(imm_word(3'b011, 5'd28, 5'd2, 12'h001));

        ////////////////////////////////////////
        // random R-type ops
        ////////////////////////////////////////
        for (i = 0; i < RANDOM_OPS; i++) begin
            rnd = $random(seed);
            rj  = reg_idx_t'(rnd % 32'd31 + 32'd1);
            rnd = $random(seed);
            rk  = reg_idx_t'(rnd % 32'd31 + 32'd1);
            rnd = $random(seed);
            rd  = reg_idx_t'(rnd % 32'd31 + 32'd1);
            va  = $random(seed);
            vb  = $random(seed);
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0:    op = ALU_ADD;
                2'd1:    op = ALU_SUB;
                2'd2:    op = ALU_XOR;
                default: op = ALU_SLTU;
            endcase
            apb_write(rf_addr(rj), va);
            apb_write(rf_addr(rk), vb);
            // same register for both operands keeps the second value
            if (rj == rk) begin
                va = vb;
            end
            apb_write(ADDR_INST, rtype_word(op, rd, rj, rk));
            valid_issued++;
            apb_read(rf_addr(rd), got);
            check_word($sformatf("r%0d", rd), got, expect_alu(op, va, vb));
        end

        apb_read(ADDR_RETIRED, got);
        check_word("retired", got, word_t'(valid_issued));

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* logic/la_exec_top.sv */
// la_exec_top
// LA32R execution unit top, APB port in front of the
// decode, execute and result stages

`timescale 1ns/1ps

module la_exec_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  la_pkg::addr_t paddr,
    input  la_pkg::word_t pwdata,
    output la_pkg::word_t prdata,
    output logic          pready,
    output logic          pslverr
);
    import la_pkg::*;

    logic     issue;
    word_t    inst;
    logic     done;
    logic     host_we;
    reg_idx_t host_idx;
    word_t    host_wdata;
    word_t    host_rdata;
    logic     flag_clear;
    word_t    retired;
    logic     invalid_flag;
    reg_idx_t rj_addr;
    reg_idx_t rk_addr;
    word_t    rj_data;
    word_t    rk_data;

    la_uop_if u_uop ();
    la_wb_if  u_wb ();

    la_apb_port u_apb (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .done         (done),
        .host_rdata   (host_rdata),
        .retired      (retired),
        .invalid_flag (invalid_flag),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .issue        (issue),
        .inst         (inst),
        .host_we      (host_we),
        .host_idx     (host_idx),
        .host_wdata   (host_wdata),
        .flag_clear   (flag_clear)
    );

    la_decode u_decode (
        .issue (issue),
        .inst  (inst),
        .uop   (u_uop.uop)
    );

    la_execute u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .uop     (u_uop.ex),
        .rj_data (rj_data),
        .rk_data (rk_data),
        .rj_addr (rj_addr),
        .rk_addr (rk_addr),
        .wb      (u_wb.wb)
    );

    la_result u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb           (u_wb.res),
        .rj_addr      (rj_addr),
        .rk_addr      (rk_addr),
        .host_we      (host_we),
        .host_idx     (host_idx),
        .host_wdata   (host_wdata),
        .flag_clear   (flag_clear),
        .rj_data      (rj_data),
        .rk_data      (rk_data),
        .host_rdata   (host_rdata),
        .retired      (retired),
        .invalid_flag (invalid_flag),
        .done         (done)
    );

endmodule

/* logic/la_apb_port.sv */
// la_apb_port
// APB slave, command register, issue strobe, busy stall,
// read mux and error response

`timescale 1ns/1ps

module la_apb_port (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  la_pkg::addr_t    paddr,
    input  la_pkg::word_t    pwdata,
    input  logic             done,
    input  la_pkg::word_t    host_rdata,
    input  la_pkg::word_t    retired,
    input  logic             invalid_flag,
    output la_pkg::word_t    prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             issue,
    output la_pkg::word_t    inst,
    output logic             host_we,
    output la_pkg::reg_idx_t host_idx,
    output la_pkg::word_t    host_wdata,
    output logic             flag_clear
);
    import la_pkg::*;

    logic  busy;
    logic  hit_inst;
    logic  hit_status;
    logic  hit_retired;
    logic  hit_rf;
    logic  err;
    logic  xfer;
    logic  wr_ok;
    word_t status;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////
    assign hit_inst    = paddr == ADDR_INST;
    assign hit_status  = paddr == ADDR_STATUS;
    assign hit_retired = paddr == ADDR_RETIRED;
    assign hit_rf      = paddr[11:7] == ADDR_RF_BASE[11:7] && paddr[1:0] == 2'b00;
    // unmapped, or a read of the write-only command register
    assign err = !(hit_inst || hit_status || hit_retired || hit_rf) ||
                 (hit_inst && !pwrite);

    // stall every access while an instruction is in flight
    assign pready  = !busy;
    assign xfer    = psel && penable && !busy;
    assign pslverr = xfer && err;
    assign wr_ok   = xfer && pwrite && !err;

    // host side of the register file
    assign host_we    = wr_ok && hit_rf;
    assign host_idx   = paddr[6:2];
    assign host_wdata = pwdata;
    assign flag_clear = wr_ok && hit_status && pwdata[STATUS_INVALID];

    always_comb begin
        status                 = '0;
        status[STATUS_BUSY]    = busy;
        status[STATUS_INVALID] = invalid_flag;
    end

    // read mux
    always_comb begin
        prdata = '0;
        if (hit_status) begin
            prdata = status;
        end else if (hit_retired) begin
            prdata = retired;
        end else if (hit_rf) begin
            prdata = host_rdata;
        end
    end

    ////////////////////////////////////////
    // command register and busy
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            issue <= 1'b0;
        end else begin
            issue <= wr_ok && hit_inst;
            if (wr_ok && hit_inst) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && hit_inst) begin
            inst <= pwdata;
        end
    end

endmodule

/* logic/la_result.sv */
// la_result
// register file with writeback, retired counter and the
// sticky invalid flag; also serves host and operand reads

`timescale 1ns/1ps

module la_result (
    input  logic             clk,
    input  logic             rst_n,
    la_wb_if.res             wb,
    input  la_pkg::reg_idx_t rj_addr,
    input  la_pkg::reg_idx_t rk_addr,
    input  logic             host_we,
    input  la_pkg::reg_idx_t host_idx,
    input  la_pkg::word_t    host_wdata,
    input  logic             flag_clear,
    output la_pkg::word_t    rj_data,
    output la_pkg::word_t    rk_data,
    output la_pkg::word_t    host_rdata,
    output la_pkg::word_t    retired,
    output logic             invalid_flag,
    output logic             done
);
    import la_pkg::*;

    word_t regs [NUM_REGS];
    logic  wb_write;

    // invalid records and r0 never land in the file
    assign wb_write = wb.valid && !wb.invalid && wb.rd != 5'd0;

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb.rd] <= wb.data;
        end else if (host_we && host_idx != 5'd0) begin
            regs[host_idx] <= host_wdata;
        end
    end

    // r0 is never written, so it reads zero
    assign rj_data    = regs[rj_addr];
    assign rk_data    = regs[rk_addr];
    assign host_rdata = regs[host_idx];

    ////////////////////////////////////////
    // retire bookkeeping
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired      <= '0;
            invalid_flag <= 1'b0;
            done         <= 1'b0;
        end else begin
            done <= wb.valid;
            if (flag_clear) begin
                invalid_flag <= 1'b0;
            end
            if (wb.valid && wb.invalid) begin
                invalid_flag <= 1'b1;
            end
            if (wb.valid && !wb.invalid) begin
                retired <= retired + 32'd1;
            end
        end
    end

endmodule

/* logic/la_execute.sv */
// la_execute
// ALU stage, picks operands, computes, and registers
// one writeback record

`timescale 1ns/1ps

module la_execute (
    input  logic              clk,
    input  logic              rst_n,
    la_uop_if.ex              uop,
    input  la_pkg::word_t     rj_data,
    input  la_pkg::word_t     rk_data,
    output la_pkg::reg_idx_t  rj_addr,
    output la_pkg::reg_idx_t  rk_addr,
    la_wb_if.wb               wb
);
    import la_pkg::*;

    word_t    op1;
    word_t    op2;
    word_t    result;
    logic [4:0] shamt;

    // register file read ports
    assign rj_addr = uop.rj;
    assign rk_addr = uop.rk;

    assign op1   = (uop.src1 == SRC1_ZERO) ? '0 : rj_data;
    assign op2   = (uop.src2 == SRC2_IMM) ? uop.imm : rk_data;
    // shift amount is mod 32
    assign shamt = op2[4:0];

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb begin
        case (uop.alu_op)
            ALU_ADD:  result = op1 + op2;
            ALU_SUB:  result = op1 - op2;
            ALU_SLT:  result = {31'b0, $signed(op1) < $signed(op2)};
            ALU_SLTU: result = {31'b0, op1 < op2};
            ALU_NOR:  result = ~(op1 | op2);
            ALU_AND:  result = op1 & op2;
            ALU_OR:   result = op1 | op2;
            ALU_XOR:  result = op1 ^ op2;
            ALU_SLL:  result = op1 << shamt;
            ALU_SRL:  result = op1 >> shamt;
            ALU_SRA:  result = word_t'($signed(op1) >>> shamt);
            default:  result = '0;
        endcase
    end

    ////////////////////////////////////////
    // writeback record
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= uop.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb.invalid <= uop.invalid;
        wb.rd      <= uop.rd;
        wb.data    <= result;
    end

endmodule

/* logic/la_decode.sv */
// la_decode
// combinational LA32R subset decoder, turns the issued
// instruction word into one uop

`timescale 1ns/1ps

module la_decode (
    input  logic          issue,
    input  la_pkg::word_t inst,
    la_uop_if.uop         uop
);
    import la_pkg::*;

    logic    is_alu;
    logic    is_sra;
    logic    is_alu_imm;
    logic    is_sfti;
    logic    is_lui;
    logic    op_bad;
    alu_op_t alu_op;
    word_t   imm;

    ////////////////////////////////////////
    // instruction groups
    ////////////////////////////////////////
    assign is_alu     = inst[30:19] == 12'b000000000010;
    assign is_sra     = inst[30:15] == 16'b0000000000110000;
    assign is_alu_imm = inst[30:25] == 6'b000001;
    assign is_sfti    = inst[30:20] == 11'b00000000100 && inst[17:15] == 3'b001;
    assign is_lui     = inst[30:25] == 6'b001010;

    ////////////////////////////////////////
    // ALU op selection
    ////////////////////////////////////////
    always_comb begin
        alu_op = ALU_ADD;
        op_bad = 1'b0;
        if (is_alu) begin
            alu_op = inst[18:15];
            // only the listed R-type codes exist in the subset
            case (inst[18:15])
                ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR,
                ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL: op_bad = 1'b0;
                default: op_bad = 1'b1;
            endcase
        end else if (is_sra) begin
            alu_op = ALU_SRA;
        end else if (is_alu_imm) begin
            case (inst[24:22])
                3'b000: alu_op = ALU_SLT;
                3'b001: alu_op = ALU_SLTU;
                3'b010: alu_op = ALU_ADD;
                3'b101: alu_op = ALU_AND;
                3'b110: alu_op = ALU_OR;
                3'b111: alu_op = ALU_XOR;
                // addi.d, lu52i.d slots
                default: op_bad = 1'b1;
            endcase
        end else if (is_sfti) begin
            case (inst[19:18])
                2'b00:   alu_op = ALU_SLL;
                2'b01:   alu_op = ALU_SRL;
                2'b10:   alu_op = ALU_SRA;
                default: op_bad = 1'b1;
            endcase
        end
    end

    ////////////////////////////////////////
    // immediates
    ////////////////////////////////////////
    always_comb begin
        imm = '0;
        if (is_alu_imm && !inst[24]) begin
            // slti, sltui, addi.w
            imm = {{20{inst[21]}}, inst[21:10]};
        end else if (is_alu_imm) begin
            // andi, ori, xori
            imm = {20'b0, inst[21:10]};
        end else if (is_sfti) begin
            imm = {27'b0, inst[14:10]};
        end else if (is_lui) begin
            imm = {inst[24:5], 12'b0};
        end
    end

    // operand sources
    assign uop.src1 = is_lui ? SRC1_ZERO : SRC1_RF;
    assign uop.src2 = (is_alu_imm || is_sfti || is_lui) ? SRC2_IMM : SRC2_RF;

    // register fields
    // unused read ports point at r0
    assign uop.rd = inst[4:0];
    assign uop.rj = is_lui ? 5'd0 : inst[9:5];
    assign uop.rk = (is_alu || is_sra) ? inst[14:10] : 5'd0;

    assign uop.alu_op  = alu_op;
    assign uop.imm     = imm;
    assign uop.valid   = issue;
    assign uop.invalid = inst[31] || op_bad ||
                         !(is_alu || is_sra || is_alu_imm || is_sfti || is_lui);

endmodule

/* logic/la_uop_if.sv */
// la_uop_if / la_wb_if
// decode to execute uop bundle, execute to result writeback record

`timescale 1ns/1ps

interface la_uop_if;
    import la_pkg::*;

    logic     valid;
    logic     invalid;
    alu_op_t  alu_op;
    src1_t    src1;
    src2_t    src2;
    word_t    imm;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;

    modport uop (output valid, invalid, alu_op, src1, src2, imm, rd, rj, rk);
    modport ex  (input  valid, invalid, alu_op, src1, src2, imm, rd, rj, rk);
endinterface

interface la_wb_if;
    import la_pkg::*;

    logic     valid;
    logic     invalid;
    reg_idx_t rd;
    word_t    data;

    modport wb  (output valid, invalid, rd, data);
    modport res (input  valid, invalid, rd, data);
endinterface

/* logic/la_pkg.sv */
// la_pkg
// shared widths, types, ALU op codes and the APB address map
// of the LA32R integer execution unit

package la_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic        src1_t;
    typedef logic        src2_t;

    localparam int NUM_REGS = 32;

    ////////////////////////////////////////
    // ALU op codes
    ////////////////////////////////////////
    // R-type codes are inst[18:15] as is
    localparam alu_op_t ALU_ADD  = 4'd0;
    // sra.w sits outside the R-type group, so it borrows an unused code
    localparam alu_op_t ALU_SRA  = 4'd1;
    localparam alu_op_t ALU_SUB  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd4;
    localparam alu_op_t ALU_SLTU = 4'd5;
    localparam alu_op_t ALU_NOR  = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;
    localparam alu_op_t ALU_OR   = 4'd10;
    localparam alu_op_t ALU_XOR  = 4'd11;
    localparam alu_op_t ALU_SLL  = 4'd14;
    localparam alu_op_t ALU_SRL  = 4'd15;

    // operand sources
    localparam src1_t SRC1_RF   = 1'b0;
    localparam src1_t SRC1_ZERO = 1'b1;
    localparam src2_t SRC2_RF   = 1'b0;
    localparam src2_t SRC2_IMM  = 1'b1;

    ////////////////////////////////////////
    // APB address map
    ////////////////////////////////////////
    localparam addr_t ADDR_INST    = 12'h000;
    localparam addr_t ADDR_STATUS  = 12'h004;
    localparam addr_t ADDR_RETIRED = 12'h008;
    // r(n) lives at base + 4n
    localparam addr_t ADDR_RF_BASE = 12'h080;

    // STATUS bit positions
    localparam int STATUS_BUSY    = 0;
    localparam int STATUS_INVALID = 1;

endpackage
